// File: hw/bp_pkg.sv
//////////////////////////////////////////////////
// Branch prediction package
// Geometry, shared address and id types, BTB entry
// and per-id metadata records, index and tag helpers
//////////////////////////////////////////////////
package bp_pkg;

    //////////////////////////////////////////////////
    // Geometry
    localparam int ADDR_W      = 32;
    localparam int BTB_WAYS    = 2;
    localparam int BTB_WAY_W   = $clog2(BTB_WAYS);
    localparam int BTB_INDEX_W = 4;
    localparam int BTB_SETS    = 1 << BTB_INDEX_W;
    // Tag covers everything above the index and the word offset
    localparam int BTB_TAG_W   = ADDR_W - BTB_INDEX_W - 2;
    localparam int ID_W        = 3;
    localparam int MAX_IDS     = 1 << ID_W;
    localparam int RAS_DEPTH   = 4;
    localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_W   = $clog2(RAS_DEPTH + 1);

    //////////////////////////////////////////////////
    // Types
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0] id_t;
    typedef logic [BTB_WAYS-1:0] way_mask_t;
    typedef logic [BTB_INDEX_W-1:0] btb_index_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    typedef enum logic [1:0] {
        BP_COND = 2'b00,
        BP_JUMP = 2'b01,
        BP_CALL = 2'b10,
        BP_RET  = 2'b11
    } bp_kind_t;

    // Upper bit set means predicted taken
    typedef logic [1:0] counter_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        bp_kind_t kind;
        counter_t counter;
    } btb_entry_t;

    // Captured at fetch, consumed at resolve
    typedef struct packed {
        counter_t  counter;
        logic      hit;
        way_mask_t way_mask;
    } bp_meta_t;

    //////////////////////////////////////////////////
    // Address split
    function automatic btb_index_t get_index(input addr_t addr);
        return addr[BTB_INDEX_W+1:2];
    endfunction

    function automatic btb_tag_t get_tag(input addr_t addr);
        return addr[ADDR_W-1:BTB_INDEX_W+2];
    endfunction

endpackage

// File: hw/branch_predict_top.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Fetch-stage branch prediction top
// BTB, return address stack and next-pc select
//////////////////////////////////////////////////
module branch_predict_top
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Fetch side
    input  addr_t    next_pc,
    input  logic     lookup_en,
    input  addr_t    if_pc,
    input  id_t      pc_id,
    input  logic     pc_id_assigned,
    // Execute side
    input  logic     br_valid,
    input  id_t      br_id,
    input  addr_t    br_pc,
    input  addr_t    br_target,
    input  logic     br_taken,
    input  bp_kind_t br_kind,
    // Prediction
    output addr_t    fetch_target,
    output logic     prediction_taken,
    output logic     btb_hit,
    output bp_kind_t hit_kind,
    output logic     ras_empty
);

    logic lookup_hit;
    bp_kind_t lookup_kind;
    counter_t lookup_counter;
    addr_t lookup_target;
    addr_t ras_top;

    branch_target_buffer btb_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en      (lookup_en),
        .next_pc        (next_pc),
        .if_pc          (if_pc),
        .pc_id_assigned (pc_id_assigned),
        .pc_id          (pc_id),
        .br_valid       (br_valid),
        .br_id          (br_id),
        .br_pc          (br_pc),
        .br_target      (br_target),
        .br_taken       (br_taken),
        .br_kind        (br_kind),
        .lookup_hit     (lookup_hit),
        .lookup_kind    (lookup_kind),
        .lookup_counter (lookup_counter),
        .lookup_target  (lookup_target)
    );

    return_address_stack ras_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .br_valid  (br_valid),
        .br_kind   (br_kind),
        .br_pc     (br_pc),
        .ras_top   (ras_top),
        .ras_empty (ras_empty)
    );

    fetch_pc_select sel_i (
        .if_pc            (if_pc),
        .lookup_hit       (lookup_hit),
        .lookup_kind      (lookup_kind),
        .lookup_counter   (lookup_counter),
        .lookup_target    (lookup_target),
        .ras_top          (ras_top),
        .ras_empty        (ras_empty),
        .fetch_target     (fetch_target),
        .prediction_taken (prediction_taken)
    );

    // Raw lookup status for the fetch stage
    assign btb_hit  = lookup_hit;
    assign hit_kind = lookup_kind;

endmodule

// File: hw/branch_target_buffer.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Two-way branch target buffer
// Tag and target banks read at fetch
// Per-id metadata steers the resolve update to its way
//////////////////////////////////////////////////
module branch_target_buffer
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Fetch side
    input  logic     lookup_en,
    input  addr_t    next_pc,
    input  addr_t    if_pc,
    input  logic     pc_id_assigned,
    input  id_t      pc_id,
    // Execute side
    input  logic     br_valid,
    input  id_t      br_id,
    input  addr_t    br_pc,
    input  addr_t    br_target,
    input  logic     br_taken,
    input  bp_kind_t br_kind,
    // Lookup result, one cycle after lookup_en
    output logic     lookup_hit,
    output bp_kind_t lookup_kind,
    output counter_t lookup_counter,
    output addr_t    lookup_target
);

    btb_entry_t if_entry [BTB_WAYS];
    addr_t way_target [BTB_WAYS];
    btb_entry_t ex_entry;

    way_mask_t tag_match;
    way_mask_t hit_mask;
    way_mask_t replace_way;
    way_mask_t tag_we;
    way_mask_t target_we;
    logic [BTB_WAY_W-1:0] hit_way;

    bp_meta_t meta_wr;
    bp_meta_t meta_ex;
    counter_t new_counter;
    logic dir_changed;

    //////////////////////////////////////////////////
    // Tag and target banks
    generate
        for (genvar w = 0; w < BTB_WAYS; w++) begin : gen_ways
            sdp_ram #(
                .data_t (btb_entry_t),
                .DEPTH  (BTB_SETS)
            ) tag_bank (
                .clk   (clk),
                .rst_n (rst_n),
                .we    (tag_we[w]),
                .waddr (get_index(br_pc)),
                .wdata (ex_entry),
                .re    (lookup_en),
                .raddr (get_index(next_pc)),
                .rdata (if_entry[w])
            );

            sdp_ram #(
                .data_t (addr_t),
                .DEPTH  (BTB_SETS)
            ) target_bank (
                .clk   (clk),
                .rst_n (rst_n),
                .we    (target_we[w]),
                .waddr (get_index(br_pc)),
                .wdata (br_target),
                .re    (lookup_en),
                .raddr (get_index(next_pc)),
                .rdata (way_target[w])
            );

            assign tag_match[w] = if_entry[w].valid && (if_entry[w].tag == get_tag(if_pc));
        end
    endgenerate

    //////////////////////////////////////////////////
    // Hit detection
    // Lowest matching way wins if a pc sits in both
    always_comb begin
        hit_way = '0;
        for (int w = BTB_WAYS - 1; w >= 0; w--) begin
            if (tag_match[w]) begin
                hit_way = BTB_WAY_W'(w);
            end
        end
    end

    assign hit_mask       = way_mask_t'(1) << hit_way;
    assign lookup_hit     = |tag_match;
    assign lookup_kind    = if_entry[hit_way].kind;
    assign lookup_counter = if_entry[hit_way].counter;
    assign lookup_target  = way_target[hit_way];

    //////////////////////////////////////////////////
    // Replacement pointer and metadata
    // One-hot pointer that advances on every recorded miss
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            replace_way <= way_mask_t'(1);
        end else if (pc_id_assigned && !lookup_hit) begin
            replace_way <= {replace_way[BTB_WAYS-2:0], replace_way[BTB_WAYS-1]};
        end
    end

    always_comb begin
        meta_wr.counter  = lookup_counter;
        meta_wr.hit      = lookup_hit;
        meta_wr.way_mask = lookup_hit ? hit_mask : replace_way;
    end

    sdp_ram #(
        .data_t    (bp_meta_t),
        .DEPTH     (MAX_IDS),
        .COMB_READ (1'b1)
    ) meta_table (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (pc_id_assigned),
        .waddr (pc_id),
        .wdata (meta_wr),
        .re    (br_valid),
        .raddr (br_id),
        .rdata (meta_ex)
    );

    //////////////////////////////////////////////////
    // Resolve update
    // Saturating counter, or a fresh strong state after a miss
    always_comb begin
        if (!meta_ex.hit) begin
            new_counter = br_taken ? 2'b11 : 2'b00;
        end else if (br_taken) begin
            new_counter = (meta_ex.counter == 2'b11) ? 2'b11 : meta_ex.counter + 2'b01;
        end else begin
            new_counter = (meta_ex.counter == 2'b00) ? 2'b00 : meta_ex.counter - 2'b01;
        end
    end

    always_comb begin
        ex_entry.valid   = 1'b1;
        ex_entry.tag     = get_tag(br_pc);
        ex_entry.kind    = br_kind;
        ex_entry.counter = new_counter;
    end

    // Target only rewritten on a direction flip or a new entry
    assign dir_changed = !meta_ex.hit || (meta_ex.counter[1] != new_counter[1]);
    assign tag_we      = {BTB_WAYS{br_valid}} & meta_ex.way_mask;
    assign target_we   = {BTB_WAYS{dir_changed}} & tag_we;

endmodule

// File: hw/fetch_pc_select.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Next fetch address select
// Merges BTB lookup and RAS top into the fetch target
//////////////////////////////////////////////////
module fetch_pc_select
    import bp_pkg::*;
(
    input  addr_t    if_pc,
    input  logic     lookup_hit,
    input  bp_kind_t lookup_kind,
    input  counter_t lookup_counter,
    input  addr_t    lookup_target,
    input  addr_t    ras_top,
    input  logic     ras_empty,
    output addr_t    fetch_target,
    output logic     prediction_taken
);

    addr_t seq_pc;
    logic use_ras;
    logic use_btb;

    assign seq_pc = if_pc + ADDR_W'(4);

    // Decide the source first, then mux the address
    always_comb begin
        use_ras = 1'b0;
        use_btb = 1'b0;
        if (lookup_hit) begin
            case (lookup_kind)
                BP_RET: begin
                    // Falls through when the stack is empty
                    use_ras = !ras_empty;
                end
                BP_JUMP, BP_CALL: begin
                    use_btb = 1'b1;
                end
                default: begin
                    use_btb = lookup_counter[1];
                end
            endcase
        end
    end

    always_comb begin
        if (use_ras) begin
            fetch_target = ras_top;
        end else if (use_btb) begin
            fetch_target = lookup_target;
        end else begin
            fetch_target = seq_pc;
        end
    end

    assign prediction_taken = use_ras || use_btb;

endmodule

// File: hw/return_address_stack.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Return address stack
// Circular, pushed by resolved calls, popped by returns
//////////////////////////////////////////////////
module return_address_stack
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     br_valid,
    input  bp_kind_t br_kind,
    input  addr_t    br_pc,
    output addr_t    ras_top,
    output logic     ras_empty
);

    addr_t stack [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] top_ptr;
    logic [RAS_CNT_W-1:0] count;
    logic push;
    logic pop;

    assign push = br_valid && (br_kind == BP_CALL);
    // Pop on an empty stack is dropped
    assign pop  = br_valid && (br_kind == BP_RET) && (count != '0);

    //////////////////////////////////////////////////
    // Pointer and occupancy
    // A full push wraps onto the oldest entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (push) begin
            top_ptr <= top_ptr + 1'b1;
            if (count != RAS_CNT_W'(RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            // Return lands after the call instruction
            stack[top_ptr + 1'b1] <= br_pc + ADDR_W'(4);
        end
    end

    assign ras_top   = stack[top_ptr];
    assign ras_empty = (count == '0);

endmodule

// File: hw/sdp_ram.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Simple dual-port RAM, one write and one read port
// Payload given by type, read registered by default
// Old data is returned on a read/write collision
//////////////////////////////////////////////////
module sdp_ram #(
    parameter type data_t    = logic [31:0],
    parameter int  DEPTH     = 16,
    parameter bit  COMB_READ = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  data_t                    wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output data_t                    rdata
);

    data_t mem [DEPTH];

    // Every entry cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    generate
        if (COMB_READ) begin : gen_comb_read
            // Lookup table style read for the execute side
            assign rdata = re ? mem[raddr] : '0;
        end else begin : gen_reg_read
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    rdata <= '0;
                end else if (re) begin
                    rdata <= mem[raddr];
                end
            end
        end
    endgenerate

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
# The result is read from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module bp_tb -o bp_sim \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bp_sim +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$SIM_LOG"; then
    echo "simulation log holds no result line"
    exit 1
fi
exit 0

// File: test/bp_checker.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Fetch select assertions
// Watches the selector ports inside the predictor top
//////////////////////////////////////////////////
module bp_checker
    import bp_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input addr_t if_pc,
    input logic  lookup_hit,
    input addr_t lookup_target,
    input addr_t ras_top,
    input addr_t fetch_target,
    input logic  prediction_taken
);

    int unsigned fail_count = 0;
    addr_t seq_pc;

    assign seq_pc = if_pc + 32'd4;

    // A taken prediction must leave the sequential path
    a_taken_redirects: assert property (@(posedge clk) disable iff (!rst_n)
        prediction_taken |-> (fetch_target != seq_pc) || (lookup_target == seq_pc)
                             || (ras_top == seq_pc))
    else begin
        fail_count++;
        $error("taken prediction kept the sequential address");
    end

    a_miss_not_taken: assert property (@(posedge clk) disable iff (!rst_n)
        !lookup_hit |-> !prediction_taken)
    else begin
        fail_count++;
        $error("BTB miss produced a taken prediction");
    end

    a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({fetch_target, prediction_taken}))
    else begin
        fail_count++;
        $error("fetch select outputs hold unknown bits");
    end

endmodule

bind branch_predict_top bp_checker chk_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .if_pc            (if_pc),
    .lookup_hit       (lookup_hit),
    .lookup_target    (lookup_target),
    .ras_top          (ras_top),
    .fetch_target     (fetch_target),
    .prediction_taken (prediction_taken)
);

// File: test/bp_tb.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Branch prediction testbench
// Random fetch and resolve traffic checked against
// a behavioral BTB, metadata table and RAS model
//////////////////////////////////////////////////
module bp_tb
    import bp_pkg::*;
();

    localparam int SEED           = 54122;
    localparam int POOL_SIZE      = 12;
    localparam int TGT_POOL_SIZE  = 4;
    localparam int CYCLES_PER_TXN = 3;
    localparam int TOTAL_TXN      = 12 + 16 + 24 + 6 + 4 + 40;
    localparam int SCHED_CYCLES   = 4 + TOTAL_TXN * CYCLES_PER_TXN + 2;
    localparam int CYCLE_LIMIT    = 4 * SCHED_CYCLES;

    logic clk;
    logic rst_n;
    addr_t next_pc;
    logic lookup_en;
    addr_t if_pc;
    id_t pc_id;
    logic pc_id_assigned;
    logic br_valid;
    id_t br_id;
    addr_t br_pc;
    addr_t br_target;
    logic br_taken;
    bp_kind_t br_kind;
    addr_t fetch_target;
    logic prediction_taken;
    logic btb_hit;
    bp_kind_t hit_kind;
    logic ras_empty;

    // Index 0 and index 3 each shared by three pcs
    addr_t pc_pool [POOL_SIZE] = '{
        32'h0000_1000, 32'h0000_1040, 32'h0000_1080,
        32'h0000_200C, 32'h0000_204C, 32'h0000_208C,
        32'h0000_3014, 32'h0000_3028, 32'h0000_303C,
        32'h0000_4004, 32'h0000_5030, 32'h0000_6018
    };
    addr_t tgt_pool [TGT_POOL_SIZE] = '{
        32'h0000_8000, 32'h0000_8100, 32'h0001_0000, 32'h0000_A400
    };

    // Behavioral model state
    logic     m_valid   [BTB_WAYS][BTB_SETS];
    btb_tag_t m_tag     [BTB_WAYS][BTB_SETS];
    bp_kind_t m_kind    [BTB_WAYS][BTB_SETS];
    counter_t m_counter [BTB_WAYS][BTB_SETS];
    addr_t    m_target  [BTB_WAYS][BTB_SETS];
    int       m_replace;
    counter_t m_meta_counter [MAX_IDS];
    logic     m_meta_hit     [MAX_IDS];
    int       m_meta_way     [MAX_IDS];
    addr_t    m_stack [RAS_DEPTH];
    int       m_top;
    int       m_count;

    int checks = 0;
    int errors = 0;
    int cycle_count = 0;

    tb_clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    branch_predict_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .next_pc          (next_pc),
        .lookup_en        (lookup_en),
        .if_pc            (if_pc),
        .pc_id            (pc_id),
        .pc_id_assigned   (pc_id_assigned),
        .br_valid         (br_valid),
        .br_id            (br_id),
        .br_pc            (br_pc),
        .br_target        (br_target),
        .br_taken         (br_taken),
        .br_kind          (br_kind),
        .fetch_target     (fetch_target),
        .prediction_taken (prediction_taken),
        .btb_hit          (btb_hit),
        .hit_kind         (hit_kind),
        .ras_empty        (ras_empty)
    );

    //////////////////////////////////////////////////
    // Compare tasks
    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_kind(input string name, input bp_kind_t got, input bp_kind_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    task automatic clear_model();
        for (int w = 0; w < BTB_WAYS; w++) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                m_valid[w][s]   = 1'b0;
                m_tag[w][s]     = '0;
                m_kind[w][s]    = BP_COND;
                m_counter[w][s] = 2'd0;
                m_target[w][s]  = '0;
            end
        end
        for (int i = 0; i < MAX_IDS; i++) begin
            m_meta_counter[i] = 2'd0;
            m_meta_hit[i]     = 1'b0;
            m_meta_way[i]     = 0;
        end
        for (int i = 0; i < RAS_DEPTH; i++) begin
            m_stack[i] = '0;
        end
        m_replace = 0;
        m_top     = 0;
        m_count   = 0;
    endtask

    // Lowest matching way wins
    task automatic model_lookup(input addr_t pc, output logic hit, output int way);
        int idx;
        idx = int'(pc[5:2]);
        hit = 1'b0;
        way = 0;
        for (int w = BTB_WAYS - 1; w >= 0; w--) begin
            if (m_valid[w][idx] && (m_tag[w][idx] == pc[31:6])) begin
                hit = 1'b1;
                way = w;
            end
        end
    endtask

    task automatic model_select(input addr_t pc, input logic hit, input int way,
                                output addr_t exp_target, output logic exp_taken);
        int idx;
        idx = int'(pc[5:2]);
        exp_target = pc + 32'd4;
        exp_taken  = 1'b0;
        if (hit) begin
            if (m_kind[way][idx] == BP_RET) begin
                if (m_count != 0) begin
                    exp_target = m_stack[m_top];
                    exp_taken  = 1'b1;
                end
            end else if (m_kind[way][idx] != BP_COND || m_counter[way][idx][1]) begin
                exp_target = m_target[way][idx];
                exp_taken  = 1'b1;
            end
        end
    endtask

    task automatic model_resolve(input id_t id, input addr_t pc, input addr_t target,
                                 input logic taken, input bp_kind_t kind);
        int idx;
        int way;
        counter_t old_c;
        counter_t new_c;
        idx   = int'(pc[5:2]);
        way   = m_meta_way[id];
        old_c = m_meta_counter[id];
        if (!m_meta_hit[id]) begin
            new_c = taken ? 2'd3 : 2'd0;
        end else if (taken) begin
            new_c = (old_c == 2'd3) ? 2'd3 : old_c + 2'd1;
        end else begin
            new_c = (old_c == 2'd0) ? 2'd0 : old_c - 2'd1;
        end
        m_valid[way][idx]   = 1'b1;
        m_tag[way][idx]     = pc[31:6];
        m_kind[way][idx]    = kind;
        m_counter[way][idx] = new_c;
        if (!m_meta_hit[id] || (old_c[1] != new_c[1])) begin
            m_target[way][idx] = target;
        end
        // Stack side wraps onto the oldest entry on overflow
        if (kind == BP_CALL) begin
            m_top          = (m_top + 1) % RAS_DEPTH;
            m_stack[m_top] = pc + 32'd4;
            if (m_count < RAS_DEPTH) begin
                m_count++;
            end
        end else if (kind == BP_RET && m_count > 0) begin
            m_top = (m_top + RAS_DEPTH - 1) % RAS_DEPTH;
            m_count--;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    function automatic addr_t rand_target();
        int i;
        i = int'($urandom_range(TGT_POOL_SIZE - 1));
        return tgt_pool[i];
    endfunction

    function automatic addr_t rand_pc();
        int i;
        i = int'($urandom_range(POOL_SIZE - 1));
        return pc_pool[i];
    endfunction

    function automatic logic rand_bit();
        return $urandom_range(1) == 1;
    endfunction

    function automatic bp_kind_t rand_kind();
        case ($urandom_range(3))
            0: return BP_COND;
            1: return BP_JUMP;
            2: return BP_CALL;
            default: return BP_RET;
        endcase
    endfunction

    // Lookup, id assign with checks, then an optional resolve
    task automatic run_txn(input addr_t pc, input logic resolve, input bp_kind_t kind,
                           input logic taken, input addr_t target);
        id_t id;
        logic exp_hit;
        int way;
        int idx;
        addr_t exp_target;
        logic exp_taken;
        id  = id_t'($urandom_range(MAX_IDS - 1));
        idx = int'(pc[5:2]);
        @(posedge clk);
        br_valid  <= 1'b0;
        lookup_en <= 1'b1;
        next_pc   <= pc;
        @(posedge clk);
        lookup_en      <= 1'b0;
        if_pc          <= pc;
        pc_id          <= id;
        pc_id_assigned <= 1'b1;
        @(negedge clk);
        model_lookup(pc, exp_hit, way);
        model_select(pc, exp_hit, way, exp_target, exp_taken);
        check_bit("btb_hit", btb_hit, exp_hit);
        if (exp_hit) begin
            check_kind("hit_kind", hit_kind, m_kind[way][idx]);
        end
        check_addr("fetch_target", fetch_target, exp_target);
        check_bit("prediction_taken", prediction_taken, exp_taken);
        check_bit("ras_empty", ras_empty, m_count == 0);
        // Metadata as the fetch stage saw it
        m_meta_counter[id] = m_counter[way][idx];
        m_meta_hit[id]     = exp_hit;
        m_meta_way[id]     = exp_hit ? way : m_replace;
        if (!exp_hit) begin
            m_replace = (m_replace + 1) % BTB_WAYS;
        end
        @(posedge clk);
        pc_id_assigned <= 1'b0;
        if (resolve) begin
            br_valid  <= 1'b1;
            br_id     <= id;
            br_pc     <= pc;
            br_target <= target;
            br_taken  <= taken;
            br_kind   <= kind;
            model_resolve(id, pc, target, taken, kind);
        end
    endtask

    task automatic report_test(input int num, input string name, input int txns,
                               input int start_errors);
        $display("test %0d %s: %0d transactions, %0d mismatches", num, name, txns,
                 errors - start_errors);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        int start;
        addr_t pc;
        addr_t tgt;
        bp_kind_t kind;
        next_pc        = '0;
        lookup_en      = 1'b0;
        if_pc          = '0;
        pc_id          = '0;
        pc_id_assigned = 1'b0;
        br_valid       = 1'b0;
        br_id          = '0;
        br_pc          = '0;
        br_target      = '0;
        br_taken       = 1'b0;
        br_kind        = BP_COND;
        void'($urandom(SEED));
        clear_model();
        wait (rst_n === 1'b1);

        start = errors;
        for (int i = 0; i < POOL_SIZE; i++) begin
            run_txn(pc_pool[i], 1'b0, BP_COND, 1'b0, '0);
        end
        report_test(1, "reset_misses", POOL_SIZE, start);

        start = errors;
        for (int i = 0; i < 8; i++) begin
            pc   = rand_pc();
            tgt  = rand_target();
            kind = rand_bit() ? BP_CALL : BP_JUMP;
            run_txn(pc, 1'b1, kind, 1'b1, tgt);
            run_txn(pc, 1'b1, kind, 1'b1, tgt);
        end
        report_test(2, "jump_call_hits", 16, start);

        start = errors;
        for (int p = 0; p < 4; p++) begin
            for (int r = 0; r < 6; r++) begin
                run_txn(pc_pool[6 + p], 1'b1, BP_COND, rand_bit(), rand_target());
            end
        end
        report_test(3, "cond_counter", 24, start);

        start = errors;
        for (int i = 0; i < 3; i++) begin
            run_txn(pc_pool[i], 1'b1, BP_JUMP, 1'b1, rand_target());
        end
        for (int i = 0; i < 3; i++) begin
            run_txn(pc_pool[i], 1'b0, BP_COND, 1'b0, '0);
        end
        report_test(4, "index_evict", 6, start);

        start = errors;
        run_txn(pc_pool[10], 1'b1, BP_RET, 1'b1, rand_target());
        run_txn(pc_pool[9], 1'b1, BP_CALL, 1'b1, rand_target());
        run_txn(pc_pool[10], 1'b1, BP_RET, 1'b1, rand_target());
        run_txn(pc_pool[10], 1'b0, BP_COND, 1'b0, '0);
        report_test(5, "call_return", 4, start);

        start = errors;
        for (int i = 0; i < 40; i++) begin
            run_txn(rand_pc(), 1'b1, rand_kind(), rand_bit(), rand_target());
        end
        report_test(6, "random_mix", 40, start);

        @(posedge clk);
        br_valid <= 1'b0;
        @(posedge clk);
        $display("totals: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns
//////////////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset held low for 4 cycles
//////////////////////////////////////////////////
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verilog.f
hw/bp_pkg.sv
hw/sdp_ram.sv
hw/branch_target_buffer.sv
hw/return_address_stack.sv
hw/fetch_pc_select.sv
hw/branch_predict_top.sv
test/tb_clock_gen.sv
test/bp_checker.sv
test/bp_tb.sv
